/* Makefile */
# Verilator build and run of the chip control testbench

TOP := chip_ctrl_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* bench/chip_ctrl_tb.sv */
// Testbench for the chip control block
// Runs a table of APB transfers through the DUT and checks the bus response,
// then the clock and pad outputs against a reference model under random
// peripheral and pad inputs.

`timescale 1ns/10ps
`default_nettype none
`include "chip_ctrl_params.svh"

module chip_ctrl_tb;

  import chip_ctrl_pkg::*;

  localparam int MAX_ROWS      = 32;
  localparam int RESET_CYCLES  = 10;
  localparam int RESET_TIMEOUT = 20;
  // Random input sets checked after each transfer
  localparam int SAMPLES       = 4;

  logic              soc_clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  apb_addr_t         paddr;
  apb_data_t         pwdata;
  apb_data_t         prdata;
  logic              pslverr;
  logic              pad_byp;
  logic              jtag_byp;
  logic [CLK_SLOW:0] clk_en;
  logic [CLK_SLOW:0] clk_byp;
  pad_vec_t          gpio_out;
  pad_vec_t          gpio_oe;
  pad_vec_t          gpio_in;
  logic              uart_tx;
  logic              uart_rx;
  logic [`CHIP_CTRL_TIMER_CH_COUNT-1:0] timer_ch;
  pad_vec_t          pad_in;
  pad_vec_t          pad_out;
  pad_vec_t          pad_oe;

  // Stimulus table, one APB transfer per row
  logic      row_write [MAX_ROWS];
  apb_addr_t row_addr [MAX_ROWS];
  apb_data_t row_wdata [MAX_ROWS];
  apb_data_t row_rdata [MAX_ROWS];
  logic      row_err [MAX_ROWS];
  logic      row_pad_byp [MAX_ROWS];
  logic      row_jtag_byp [MAX_ROWS];
  string     row_name [MAX_ROWS];
  int        num_rows;

  // Reference model state
  logic [2*CLK_SLOW+1:0]             model_clk;
  logic [2*`CHIP_CTRL_PAD_COUNT-1:0] model_pad;

  integer seed;
  int     err_count;
  int     pass_rows;
  int     fail_rows;

  chip_ctrl_top chip_ctrl_top_i (
    .soc_clk_i         ( soc_clk  ),
    .rst_i             ( rst      ),
    .psel_i            ( psel     ),
    .penable_i         ( penable  ),
    .pwrite_i          ( pwrite   ),
    .paddr_i           ( paddr    ),
    .pwdata_i          ( pwdata   ),
    .prdata_o          ( prdata   ),
    .pslverr_o         ( pslverr  ),
    .pad_clk_byp_en_i  ( pad_byp  ),
    .jtag_clk_byp_en_i ( jtag_byp ),
    .clk_en_o          ( clk_en   ),
    .clk_byp_o         ( clk_byp  ),
    .gpio_out_i        ( gpio_out ),
    .gpio_oe_i         ( gpio_oe  ),
    .gpio_in_o         ( gpio_in  ),
    .uart_tx_i         ( uart_tx  ),
    .uart_rx_o         ( uart_rx  ),
    .timer_ch_i        ( timer_ch ),
    .pad_in_i          ( pad_in   ),
    .pad_out_o         ( pad_out  ),
    .pad_oe_o          ( pad_oe   )
  );

  initial begin
    soc_clk = 1'b0;
    forever #5 soc_clk = ~soc_clk;
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s error flag got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pads(input pad_vec_t got, input pad_vec_t exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_clk(input logic [CLK_SLOW:0] got, input logic [CLK_SLOW:0] exp,
                           input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic add_row(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                         input apb_data_t rdata, input logic err, input logic pbyp,
                         input logic jbyp, input string name);
    row_write[num_rows]    = wr;
    row_addr[num_rows]     = addr;
    row_wdata[num_rows]    = wdata;
    row_rdata[num_rows]    = rdata;
    row_err[num_rows]      = err;
    row_pad_byp[num_rows]  = pbyp;
    row_jtag_byp[num_rows] = jbyp;
    row_name[num_rows]     = name;
    num_rows++;
  endtask

  task automatic build_table();
    num_rows = 0;
    // Reset state and clock register
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0015, 1'b0, 1'b0, 1'b0, "reset clock value");
    add_row(1'b1, 12'h000, 32'h0000_002A, 32'h0, 1'b0, 1'b0, 1'b0, "clock all bypass");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_002A, 1'b0, 1'b0, 1'b0, "clock readback 2a");
    add_row(1'b1, 12'h000, 32'h0000_0007, 32'h0, 1'b0, 1'b0, 1'b0, "clock mixed bits");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0007, 1'b0, 1'b0, 1'b0, "clock readback 07");
    // Global bypass requests
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0007, 1'b0, 1'b1, 1'b0, "pad bypass");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0007, 1'b0, 1'b0, 1'b1, "jtag bypass");
    add_row(1'b1, 12'h000, 32'hFFFF_FF15, 32'h0, 1'b0, 1'b0, 1'b0, "clock upper bits");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0015, 1'b0, 1'b0, 1'b0, "clock upper dropped");
    // Pad functions, p0..p7 = GPIO UART TIMER OFF GPIO TIMER UART GPIO
    add_row(1'b0, 12'h100, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, "pad reset value");
    add_row(1'b1, 12'h100, 32'h0000_6D39, 32'h0, 1'b0, 1'b0, 1'b0, "pad mixed functions");
    add_row(1'b0, 12'h100, 32'h0, 32'h0000_6D39, 1'b0, 1'b0, 1'b0, "pad readback");
    // UART receive routing
    add_row(1'b1, 12'h100, 32'h0000_A000, 32'h0, 1'b0, 1'b0, 1'b0, "uart on pads 6 7");
    add_row(1'b1, 12'h100, 32'h0000_0808, 32'h0, 1'b0, 1'b0, 1'b0, "uart on pads 1 5");
    add_row(1'b0, 12'h100, 32'h0, 32'h0000_0808, 1'b0, 1'b0, 1'b0, "uart readback");
    add_row(1'b1, 12'h100, 32'h0000_5555, 32'h0, 1'b0, 1'b0, 1'b0, "all gpio no uart");
    add_row(1'b1, 12'h100, 32'hFFFF_FFFF, 32'h0, 1'b0, 1'b0, 1'b0, "all timer");
    add_row(1'b0, 12'h100, 32'h0, 32'h0000_FFFF, 1'b0, 1'b0, 1'b0, "timer readback");
    // Decode errors and unused offsets
    add_row(1'b0, 12'h200, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, "unmapped read");
    add_row(1'b1, 12'h200, 32'h0000_002A, 32'h0, 1'b1, 1'b0, 1'b0, "unmapped write");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0015, 1'b0, 1'b0, 1'b0, "clock unchanged");
    add_row(1'b0, 12'h104, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, "unused pad offset");
    add_row(1'b1, 12'h104, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, "unused pad write");
    add_row(1'b0, 12'h100, 32'h0, 32'h0000_FFFF, 1'b0, 1'b0, 1'b0, "pad unchanged");
    add_row(1'b1, 12'h004, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, "unused clock write");
    add_row(1'b0, 12'h000, 32'h0, 32'h0000_0015, 1'b0, 1'b0, 1'b0, "clock still 15");
    add_row(1'b0, 12'hFFF, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0, "top of address space");
  endtask

  ////////////////////
  // Bus and model
  ////////////////////
  // Setup then access cycle, response sampled mid access cycle
  task automatic apb_transfer(input int r, output apb_data_t rdata, output logic err);
    @(negedge soc_clk);
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = row_write[r];
    paddr    = row_addr[r];
    pwdata   = row_wdata[r];
    pad_byp  = row_pad_byp[r];
    jtag_byp = row_jtag_byp[r];
    @(negedge soc_clk);
    penable = 1'b1;
    #2;
    rdata = prdata;
    err   = pslverr;
    @(negedge soc_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Only offset 0 of a mapped region holds a register
  task automatic update_model(input int r);
    if (row_write[r] && row_addr[r] == `CHIP_CTRL_CLK_START) begin
      model_clk = row_wdata[r][2*CLK_SLOW+1:0];
    end
    if (row_write[r] && row_addr[r] == `CHIP_CTRL_PAD_START) begin
      model_pad = row_wdata[r][2*`CHIP_CTRL_PAD_COUNT-1:0];
    end
  endtask

  task automatic randomize_inputs();
    logic [31:0] rnd;
    rnd      = $random(seed);
    gpio_out = rnd[7:0];
    gpio_oe  = rnd[15:8];
    pad_in   = rnd[23:16];
    uart_tx  = rnd[24];
    timer_ch = rnd[28:25];
  endtask

  task automatic check_outputs();
    logic [CLK_SLOW:0] exp_en;
    logic [CLK_SLOW:0] exp_byp;
    pad_vec_t          exp_out;
    pad_vec_t          exp_oe;
    pad_vec_t          exp_gin;
    logic              exp_rx;
    logic              uart_found;
    pad_func_e         func;
    for (int d = 0; d <= int'(CLK_SLOW); d++) begin
      exp_en[d]  = model_clk[2*d];
      exp_byp[d] = model_clk[2*d+1] | pad_byp | jtag_byp;
    end
    exp_out    = '0;
    exp_oe     = '0;
    exp_gin    = '0;
    exp_rx     = 1'b1;
    uart_found = 1'b0;
    for (int p = 0; p < `CHIP_CTRL_PAD_COUNT; p++) begin
      func = pad_func_e'(model_pad[2*p +: 2]);
      if (func == PAD_GPIO) begin
        exp_out[p] = gpio_out[p];
        exp_oe[p]  = gpio_oe[p];
        exp_gin[p] = pad_in[p];
      end else if (func == PAD_UART) begin
        exp_out[p] = uart_tx;
        exp_oe[p]  = 1'b1;
        // First UART pad found drives the receiver
        if (!uart_found) begin
          exp_rx     = pad_in[p];
          uart_found = 1'b1;
        end
      end else if (func == PAD_TIMER) begin
        exp_out[p] = timer_ch[p % `CHIP_CTRL_TIMER_CH_COUNT];
        exp_oe[p]  = 1'b1;
      end
    end
    check_clk(clk_en, exp_en, "clk_en_o");
    check_clk(clk_byp, exp_byp, "clk_byp_o");
    check_pads(pad_out, exp_out, "pad_out_o");
    check_pads(pad_oe, exp_oe, "pad_oe_o");
    check_pads(gpio_in, exp_gin, "gpio_in_o");
    check_level(uart_rx, exp_rx, "uart_rx_o");
    // Bus idle, response held at zero
    check_data(prdata, '0, "idle prdata_o");
    check_err(pslverr, 1'b0, "idle pslverr_o");
  endtask

  task automatic wait_reset_state(output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < RESET_TIMEOUT) begin
      @(negedge soc_clk);
      #2;
      ok = (clk_en == '1) && (pad_oe == '0) && (uart_rx == 1'b1);
      cycles++;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    apb_data_t rdata;
    logic      err;
    logic      ok;
    int        errs_before;
    seed      = 84415;
    err_count = 0;
    pass_rows = 0;
    fail_rows = 0;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pad_byp   = 1'b0;
    jtag_byp  = 1'b0;
    gpio_out  = '0;
    gpio_oe   = '0;
    uart_tx   = 1'b0;
    timer_ch  = '0;
    pad_in    = '0;
    model_clk = `CHIP_CTRL_CLK_RESET_VAL;
    model_pad = '0;
    build_table();
    repeat (RESET_CYCLES) @(posedge soc_clk);
    @(negedge soc_clk);
    rst = 1'b0;
    wait_reset_state(ok);
    if (!ok) begin
      $display("Timeout: DUT did not reach its reset state within %0d cycles", RESET_TIMEOUT);
      $display("TEST RESULT: FAIL");
    end else begin
      for (int r = 0; r < num_rows; r++) begin
        errs_before = err_count;
        apb_transfer(r, rdata, err);
        if (!row_write[r]) begin
          check_data(rdata, row_rdata[r], "prdata_o");
        end
        check_err(err, row_err[r], "pslverr_o");
        update_model(r);
        // Outputs already follow the register at this falling edge
        for (int s = 0; s < SAMPLES; s++) begin
          randomize_inputs();
          #2;
          check_outputs();
          @(negedge soc_clk);
        end
        if (err_count == errs_before) begin
          pass_rows++;
          $display("test %0d %s: ok", r, row_name[r]);
        end else begin
          fail_rows++;
          $display("test %0d %s: %0d mismatches", r, row_name[r], err_count - errs_before);
        end
      end
      $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
               num_rows, pass_rows, fail_rows, err_count);
      if (fail_rows == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/chip_ctrl_pkg.sv
hw/apb_chip_demux.sv
hw/clk_ctrl_regs.sv
hw/pad_mux_cfg.sv
hw/chip_ctrl_top.sv
bench/chip_ctrl_tb.sv

/* hw/apb_chip_demux.sv */
// APB decoder for the chip control block
// Maps the bus address to the clock or pad region, hands the region a select,
// write strobe, offset and data, and returns its read data. Addresses outside
// both regions get zero data with an error. Purely combinational.

`timescale 1ns/10ps
`default_nettype none
`include "chip_ctrl_params.svh"

module apb_chip_demux (
  input  wire logic                      soc_clk_i,
  input  wire logic                      rst_i,
  // APB slave side
  input  wire logic                      psel_i,
  input  wire logic                      penable_i,
  input  wire logic                      pwrite_i,
  input  wire chip_ctrl_pkg::apb_addr_t  paddr_i,
  input  wire chip_ctrl_pkg::apb_data_t  pwdata_i,
  output chip_ctrl_pkg::apb_data_t       prdata_o,
  output logic                           pslverr_o,
  // Region side
  output logic                           clk_sel_o,
  output logic                           pad_sel_o,
  output logic                           wr_o,
  output chip_ctrl_pkg::reg_offset_t     offset_o,
  output chip_ctrl_pkg::apb_data_t       wdata_o,
  input  wire chip_ctrl_pkg::apb_data_t  clk_rdata_i,
  input  wire chip_ctrl_pkg::apb_data_t  pad_rdata_i
);

  import chip_ctrl_pkg::*;

  apb_region_e region;
  logic        access;

  ////////////////////
  // Address decode
  ////////////////////
  always_comb begin
    region = REGION_ERR;
    if (paddr_i >= `CHIP_CTRL_CLK_START && paddr_i <= `CHIP_CTRL_CLK_END) begin
      region = REGION_CLK;
    end else if (paddr_i >= `CHIP_CTRL_PAD_START && paddr_i <= `CHIP_CTRL_PAD_END) begin
      region = REGION_PAD;
    end
  end

  // Second cycle of a transfer
  assign access = psel_i & penable_i;

  // One select per region, only in the access phase
  assign clk_sel_o = access && (region == REGION_CLK);
  assign pad_sel_o = access && (region == REGION_PAD);
  assign wr_o      = access & pwrite_i;

  // Regions only see the low address bits
  assign offset_o = paddr_i[`CHIP_CTRL_REG_OFFSET_WIDTH-1:0];
  assign wdata_o  = pwdata_i;

  ////////////////////
  // Response
  ////////////////////
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (access) begin
      case (region)
        REGION_CLK: prdata_o = clk_rdata_i;
        REGION_PAD: prdata_o = pad_rdata_i;
        // Unmapped, zero data and error
        default:    pslverr_o = 1'b1;
      endcase
    end
  end

  // Regions are disjoint
  a_one_region: assert property (@(posedge soc_clk_i) disable iff (rst_i)
    !(clk_sel_o && pad_sel_o));

  // Master protocol, no access phase without a select
  a_penable_psel: assert property (@(posedge soc_clk_i) disable iff (rst_i)
    penable_i |-> psel_i);

endmodule

`default_nettype wire

/* hw/chip_ctrl_params.svh */
// Address map, bus widths and sizes for the chip control block
// Include this file wherever one of these macros is needed. The package
// includes it too, so its types pick up the same widths.

`ifndef CHIP_CTRL_PARAMS_SVH
`define CHIP_CTRL_PARAMS_SVH

// APB bus widths
`define CHIP_CTRL_ADDR_WIDTH 12
`define CHIP_CTRL_DATA_WIDTH 32

// Clock control region
`define CHIP_CTRL_CLK_START 12'h000
`define CHIP_CTRL_CLK_END 12'h0FF

// Pad configuration region
`define CHIP_CTRL_PAD_START 12'h100
`define CHIP_CTRL_PAD_END 12'h1FF

// Low address bits handed to a region as its local offset
`define CHIP_CTRL_REG_OFFSET_WIDTH 8

// General purpose pads and timer channels
`define CHIP_CTRL_PAD_COUNT 8
`define CHIP_CTRL_TIMER_CH_COUNT 4

// All enables set, all bypasses clear
`define CHIP_CTRL_CLK_RESET_VAL 6'h15

`endif

/* hw/chip_ctrl_pkg.sv */
// Types shared by the chip control RTL and its testbench
// Bus words, address regions, clock domain indices and pad functions.

`include "chip_ctrl_params.svh"
`default_nettype none

package chip_ctrl_pkg;

  ////////////////////
  // APB bus
  ////////////////////
  typedef logic [`CHIP_CTRL_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [`CHIP_CTRL_DATA_WIDTH-1:0] apb_data_t;
  typedef logic [`CHIP_CTRL_REG_OFFSET_WIDTH-1:0] reg_offset_t;

  // Target of one transfer, ERR covers every unmapped address
  typedef enum logic [1:0] {
    REGION_CLK,
    REGION_PAD,
    REGION_ERR
  } apb_region_e;

  ////////////////////
  // Clock domains
  ////////////////////
  // Index into the enable and bypass vectors
  typedef enum logic [1:0] {
    CLK_SOC  = 2'd0,
    CLK_PER  = 2'd1,
    CLK_SLOW = 2'd2
  } clk_domain_e;

  ////////////////////
  // Pads
  ////////////////////
  typedef enum logic [1:0] {
    PAD_OFF   = 2'd0,
    PAD_GPIO  = 2'd1,
    PAD_UART  = 2'd2,
    PAD_TIMER = 2'd3
  } pad_func_e;

  typedef logic [`CHIP_CTRL_PAD_COUNT-1:0] pad_vec_t;
  // Pad p sits in bits 2p+1:2p
  typedef pad_func_e [`CHIP_CTRL_PAD_COUNT-1:0] pad_func_vec_t;

endpackage

`default_nettype wire

/* hw/chip_ctrl_top.sv */
// Chip control block top level
// An APB port is decoded into the clock control register and the pad
// multiplexer configuration, with an error response for unmapped addresses.
// Everything runs on soc_clk_i with the synchronous reset rst_i.

`timescale 1ns/10ps
`default_nettype none
`include "chip_ctrl_params.svh"

module chip_ctrl_top (
  input  wire logic                                  soc_clk_i,
  input  wire logic                                  rst_i,
  // APB
  input  wire logic                                  psel_i,
  input  wire logic                                  penable_i,
  input  wire logic                                  pwrite_i,
  input  wire chip_ctrl_pkg::apb_addr_t              paddr_i,
  input  wire chip_ctrl_pkg::apb_data_t              pwdata_i,
  output chip_ctrl_pkg::apb_data_t                   prdata_o,
  output logic                                       pslverr_o,
  // Clock control
  input  wire logic                                  pad_clk_byp_en_i,
  input  wire logic                                  jtag_clk_byp_en_i,
  output logic [chip_ctrl_pkg::CLK_SLOW:0]           clk_en_o,
  output logic [chip_ctrl_pkg::CLK_SLOW:0]           clk_byp_o,
  // Peripherals
  input  wire chip_ctrl_pkg::pad_vec_t               gpio_out_i,
  input  wire chip_ctrl_pkg::pad_vec_t               gpio_oe_i,
  output chip_ctrl_pkg::pad_vec_t                    gpio_in_o,
  input  wire logic                                  uart_tx_i,
  output logic                                       uart_rx_o,
  input  wire logic [`CHIP_CTRL_TIMER_CH_COUNT-1:0]  timer_ch_i,
  // Pads
  input  wire chip_ctrl_pkg::pad_vec_t               pad_in_i,
  output chip_ctrl_pkg::pad_vec_t                    pad_out_o,
  output chip_ctrl_pkg::pad_vec_t                    pad_oe_o
);

  import chip_ctrl_pkg::*;

  // Decoder to region wiring
  logic        clk_sel;
  logic        pad_sel;
  logic        wr;
  reg_offset_t offset;
  apb_data_t   wdata;
  apb_data_t   clk_rdata;
  apb_data_t   pad_rdata;

  ////////////////////
  // APB decode
  ////////////////////
  apb_chip_demux apb_chip_demux_i (
    .soc_clk_i   ( soc_clk_i ),
    .rst_i       ( rst_i     ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .prdata_o    ( prdata_o  ),
    .pslverr_o   ( pslverr_o ),
    .clk_sel_o   ( clk_sel   ),
    .pad_sel_o   ( pad_sel   ),
    .wr_o        ( wr        ),
    .offset_o    ( offset    ),
    .wdata_o     ( wdata     ),
    .clk_rdata_i ( clk_rdata ),
    .pad_rdata_i ( pad_rdata )
  );

  ////////////////////
  // Clock control
  ////////////////////
  clk_ctrl_regs clk_ctrl_regs_i (
    .soc_clk_i         ( soc_clk_i         ),
    .rst_i             ( rst_i             ),
    .sel_i             ( clk_sel           ),
    .wr_i              ( wr                ),
    .offset_i          ( offset            ),
    .wdata_i           ( wdata             ),
    .rdata_o           ( clk_rdata         ),
    .pad_clk_byp_en_i  ( pad_clk_byp_en_i  ),
    .jtag_clk_byp_en_i ( jtag_clk_byp_en_i ),
    .clk_en_o          ( clk_en_o          ),
    .clk_byp_o         ( clk_byp_o         )
  );

  ////////////////////
  // Pad multiplexer
  ////////////////////
  pad_mux_cfg pad_mux_cfg_i (
    .soc_clk_i  ( soc_clk_i  ),
    .rst_i      ( rst_i      ),
    .sel_i      ( pad_sel    ),
    .wr_i       ( wr         ),
    .offset_i   ( offset     ),
    .wdata_i    ( wdata      ),
    .rdata_o    ( pad_rdata  ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .gpio_in_o  ( gpio_in_o  ),
    .uart_tx_i  ( uart_tx_i  ),
    .uart_rx_o  ( uart_rx_o  ),
    .timer_ch_i ( timer_ch_i ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule

`default_nettype wire

/* hw/clk_ctrl_regs.sv */
// Clock control register for the soc, peripheral and slow domains
// Offset 0 holds an enable and a bypass bit per domain. Each bypass output is
// also forced by the pad and JTAG bypass inputs. Other offsets read as zero
// and ignore writes.

`timescale 1ns/10ps
`default_nettype none
`include "chip_ctrl_params.svh"

module clk_ctrl_regs (
  input  wire logic                          soc_clk_i,
  input  wire logic                          rst_i,
  // Region port from the decoder
  input  wire logic                          sel_i,
  input  wire logic                          wr_i,
  input  wire chip_ctrl_pkg::reg_offset_t    offset_i,
  input  wire chip_ctrl_pkg::apb_data_t      wdata_i,
  output chip_ctrl_pkg::apb_data_t           rdata_o,
  // Global bypass requests
  input  wire logic                          pad_clk_byp_en_i,
  input  wire logic                          jtag_clk_byp_en_i,
  // Per domain levels, indexed by clk_domain_e
  output logic [chip_ctrl_pkg::CLK_SLOW:0]   clk_en_o,
  output logic [chip_ctrl_pkg::CLK_SLOW:0]   clk_byp_o
);

  import chip_ctrl_pkg::*;

  // Bit 2d is the enable of domain d, bit 2d+1 its bypass
  logic [2*CLK_SLOW+1:0] clk_q;
  logic                  reg_hit;
  logic                  ext_byp;

  assign reg_hit = (offset_i == '0);
  assign ext_byp = pad_clk_byp_en_i | jtag_clk_byp_en_i;

  ////////////////////
  // Register
  ////////////////////
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      clk_q <= `CHIP_CTRL_CLK_RESET_VAL;
    end else if (sel_i && wr_i && reg_hit) begin
      clk_q <= wdata_i[2*CLK_SLOW+1:0];
    end
  end

  // Unused offsets read zero
  always_comb begin
    rdata_o = '0;
    if (reg_hit) begin
      rdata_o[2*CLK_SLOW+1:0] = clk_q;
    end
  end

  ////////////////////
  // Domain outputs
  ////////////////////
  always_comb begin
    for (int d = 0; d <= int'(CLK_SLOW); d++) begin
      clk_en_o[d]  = clk_q[2*d];
      // Pad or JTAG bypass overrides the register
      clk_byp_o[d] = clk_q[2*d+1] | ext_byp;
    end
  end

  // A global bypass request reaches every domain
  a_byp_forced: assert property (@(posedge soc_clk_i) disable iff (rst_i)
    ext_byp |-> (&clk_byp_o));

endmodule

`default_nettype wire

/* hw/pad_mux_cfg.sv */
// Pad function register and pad multiplexer
// Offset 0 selects off, GPIO, UART or timer per pad. Outputs and enables
// are muxed from the selected source, pad inputs are routed back to GPIO and
// the UART receiver. Other offsets read as zero and ignore writes.

`timescale 1ns/10ps
`default_nettype none
`include "chip_ctrl_params.svh"

module pad_mux_cfg (
  input  wire logic                                  soc_clk_i,
  input  wire logic                                  rst_i,
  // Region port from the decoder
  input  wire logic                                  sel_i,
  input  wire logic                                  wr_i,
  input  wire chip_ctrl_pkg::reg_offset_t            offset_i,
  input  wire chip_ctrl_pkg::apb_data_t              wdata_i,
  output chip_ctrl_pkg::apb_data_t                   rdata_o,
  // Peripheral side
  input  wire chip_ctrl_pkg::pad_vec_t               gpio_out_i,
  input  wire chip_ctrl_pkg::pad_vec_t               gpio_oe_i,
  output chip_ctrl_pkg::pad_vec_t                    gpio_in_o,
  input  wire logic                                  uart_tx_i,
  output logic                                       uart_rx_o,
  input  wire logic [`CHIP_CTRL_TIMER_CH_COUNT-1:0]  timer_ch_i,
  // Pad side
  input  wire chip_ctrl_pkg::pad_vec_t               pad_in_i,
  output chip_ctrl_pkg::pad_vec_t                    pad_out_o,
  output chip_ctrl_pkg::pad_vec_t                    pad_oe_o
);

  import chip_ctrl_pkg::*;

  pad_func_vec_t pad_func_q;
  pad_vec_t      off_pads;
  logic          reg_hit;

  assign reg_hit = (offset_i == '0);

  ////////////////////
  // Register
  ////////////////////
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      for (int p = 0; p < `CHIP_CTRL_PAD_COUNT; p++) begin
        pad_func_q[p] <= PAD_OFF;
      end
    end else if (sel_i && wr_i && reg_hit) begin
      for (int p = 0; p < `CHIP_CTRL_PAD_COUNT; p++) begin
        pad_func_q[p] <= pad_func_e'(wdata_i[2*p +: 2]);
      end
    end
  end

  // Function field sits in the low half word
  always_comb begin
    rdata_o = '0;
    if (reg_hit) begin
      rdata_o[2*`CHIP_CTRL_PAD_COUNT-1:0] = pad_func_q;
    end
  end

  ////////////////////
  // Pad multiplexer
  ////////////////////
  always_comb begin
    for (int p = 0; p < `CHIP_CTRL_PAD_COUNT; p++) begin
      gpio_in_o[p] = 1'b0;
      case (pad_func_q[p])
        PAD_GPIO: begin
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_oe_i[p];
          gpio_in_o[p] = pad_in_i[p];
        end
        PAD_UART: begin
          pad_out_o[p] = uart_tx_i;
          pad_oe_o[p]  = 1'b1;
        end
        // Timer channels repeat every four pads
        PAD_TIMER: begin
          pad_out_o[p] = timer_ch_i[p % `CHIP_CTRL_TIMER_CH_COUNT];
          pad_oe_o[p]  = 1'b1;
        end
        // Off, pad floats
        default: begin
          pad_out_o[p] = 1'b0;
          pad_oe_o[p]  = 1'b0;
        end
      endcase
    end
  end

  // Lowest UART pad wins, scan from the top so it is applied last
  always_comb begin
    uart_rx_o = 1'b1;
    for (int p = `CHIP_CTRL_PAD_COUNT - 1; p >= 0; p--) begin
      if (pad_func_q[p] == PAD_UART) begin
        uart_rx_o = pad_in_i[p];
      end
    end
  end

  // Pads configured off
  always_comb begin
    for (int p = 0; p < `CHIP_CTRL_PAD_COUNT; p++) begin
      off_pads[p] = (pad_func_q[p] == PAD_OFF);
    end
  end

  // An off pad is never driven
  a_off_no_oe: assert property (@(posedge soc_clk_i) disable iff (rst_i)
    (pad_oe_o & off_pads) == '0);

endmodule

`default_nettype wire
